// ==== sources.f ====
design/ines_pkg.sv
design/ines_header_parser.sv
design/write_fifo.sv
design/wb_mem_writer.sv
design/cart_loader_top.sv
dv/wb_mem_model.sv
dv/cart_loader_tb.sv

// ==== Makefile ====
# Verilator build and run of the cartridge loader testbench

VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := cart_loader_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/cart_loader_tb.sv ====
// Cartridge loader testbench
// Table of iNES headers applied in a loop against a Wishbone memory
// model, with a reference image of every PRG and CHR byte

`default_nettype none

module cart_loader_tb;

	// Header bytes sit with byte 0 in the top lane
	typedef struct packed {
		logic [15:0][7:0]      hdr;
		logic                  invert;
		logic                  load;	// Stream the payload and check memory
		logic                  exp_error;
		ines_pkg::cart_flags_t exp_flags;
	} row_t;

	logic                  clk = 1'b0;
	logic                  reset_nes;
	logic [7:0]            byte_data;
	logic                  byte_valid;
	logic                  invert_mirroring;
	logic                  wb_ack;
	logic                  byte_ready;
	ines_pkg::wb_m2s_t     wb;
	ines_pkg::cart_flags_t flags;
	logic                  done;
	logic                  error;

	row_t       table_rows [8];
	string      row_names [8];
	logic [7:0] expect_mem [int];	// Reference image by address
	int         seed;
	int         errors;
	int         tests_failed;
	int         stall_total;	// Cycles a payload byte waited for ready
	logic       timed_out;

	cart_loader_top dut_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_data        (byte_data),
		.byte_valid       (byte_valid),
		.invert_mirroring (invert_mirroring),
		.wb_ack           (wb_ack),
		.byte_ready       (byte_ready),
		.wb               (wb),
		.flags            (flags),
		.done             (done),
		.error            (error)
	);

	wb_mem_model mem_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wb        (wb),
		.wb_ack    (wb_ack)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("FAIL t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at t=%0t while waiting for %s", $time, what);
		timed_out = 1'b1;
		errors++;
	endtask

	function automatic logic [7:0] hdr_byte(input row_t row, input int i);
		return row.hdr[15 - i];
	endfunction

	task automatic apply_reset();
		reset_nes  = 1'b1;
		byte_valid = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset_nes = 1'b0;
	endtask

	// Holds byte_valid high and moves the byte on the first edge with ready
	task automatic send_byte(input logic [7:0] b);
		int stall;
		stall      = 0;
		byte_data  = b;
		byte_valid = 1'b1;
		while (!byte_ready && !timed_out) begin
			@(posedge clk);
			#1;
			stall++;
			stall_total++;
			if (stall > 500)
				report_timeout("byte_ready");
		end
		if (!timed_out) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic stream_section(input int base, input int len);
		logic [7:0] b;
		for (int i = 0; i < len && !timed_out; i++) begin
			b = 8'($random(seed));
			expect_mem[base + i] = b;
			send_byte(b);
		end
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && !timed_out) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 2000)
				report_timeout("done");
		end
	endtask

	task automatic check_memory(input int len);
		check_value("write count", mem_i.write_total, len);
		check_value("repeated writes", mem_i.dup_count, 0);
		foreach (expect_mem[a]) begin
			assert (mem_i.mem_bytes.exists(a))
			else begin
				$display("FAIL t=%0t address %06h was never written", $time, a);
				errors++;
			end
			if (mem_i.mem_bytes.exists(a))
				check_value($sformatf("mem[%06h]", a), 32'(mem_i.mem_bytes[a]),
				            32'(expect_mem[a]));
		end
	endtask

	////////////////////////////////////////
	// Table
	////////////////////////////////////////

	// Columns are header, {invert, load, exp_error}, flags from spare down to mapper
	task automatic fill_table();
		table_rows[0] = {128'h4E45531A_01010100_00000000_00000000, 3'b010,
		                 {2'b0, 4'h0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 3'd0, 3'd0, 8'h00}};
		table_rows[1] = {128'h4E45531A_03404B10_00000000_00000000, 3'b100,
		                 {2'b0, 4'h0, 1'b1, 8'h00, 1'b1, 1'b0, 1'b0, 3'd6, 3'd2, 8'h14}};
		table_rows[2] = {128'h4E45531A_02C80000_00000000_00000000, 3'b100,
		                 {2'b0, 4'h0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1, 3'd7, 3'd1, 8'h00}};
		table_rows[3] = {128'h4E45531A_01012040_00000744_00000000, 3'b000,
		                 {2'b0, 4'h0, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, 3'd0, 3'd0, 8'h02}};
		table_rows[4] = {128'h4E45531A_02011128_35000700_01000000, 3'b000,
		                 {2'b0, 4'h7, 1'b0, 8'h35, 1'b0, 1'b0, 1'b1, 3'd0, 3'd1, 8'h21}};
		table_rows[5] = {128'h4E45541A_01010000_00000000_00000000, 3'b001, 32'h0};
		table_rows[6] = {128'h4E45531A_01010400_00000000_00000000, 3'b001, 32'h0};
		table_rows[7] = {128'h4E45531A_01000200_00000000_00000000, 3'b010,
		                 {2'b0, 4'h0, 1'b1, 8'h00, 1'b0, 1'b1, 1'b0, 3'd0, 3'd0, 8'h00}};
		row_names = '{"ines 1.0 load", "sizes 3 and 64", "sizes 2 and 200", "dirty header",
		              "nes 2.0", "bad magic", "trainer", "chr ram load"};
	endtask

	task automatic run_row(input int r);
		row_t row;
		int   errors_before;
		int   prg_len;
		int   chr_len;
		row           = table_rows[r];
		errors_before = errors;
		prg_len       = int'(hdr_byte(row, 4)) << ines_pkg::PRG_PAGE_SHIFT;
		chr_len       = int'(hdr_byte(row, 5)) << ines_pkg::CHR_PAGE_SHIFT;
		expect_mem.delete();
		invert_mirroring = row.invert;
		apply_reset();
		check_value("byte_ready", 32'(byte_ready), 32'd1);	// Header state after reset
		check_value("done", 32'(done), 32'd0);
		check_value("error", 32'(error), 32'd0);
		check_value("wb.cyc", 32'(wb.cyc), 32'd0);
		check_value("wb.stb", 32'(wb.stb), 32'd0);
		for (int i = 0; i < ines_pkg::HEADER_LEN && !timed_out; i++)
			send_byte(hdr_byte(row, i));
		// Error and flags are valid in the cycle after the last header byte
		check_value("error", 32'(error), 32'(row.exp_error));
		if (row.exp_error) begin
			byte_valid = 1'b0;
			check_value("byte_ready", 32'(byte_ready), 32'd0);
			repeat (8) @(posedge clk);
			#1;
			check_value("cyc seen", 32'(mem_i.cyc_seen), 32'd0);
			check_value("done", 32'(done), 32'd0);
		end else begin
			check_value("flags", flags, row.exp_flags);
			if (row.load) begin
				stall_total = 0;
				stream_section(int'(ines_pkg::PRG_BASE), prg_len);
				stream_section(int'(ines_pkg::CHR_BASE), chr_len);
				byte_valid = 1'b0;
				wait_for_done();
				check_value("error", 32'(error), 32'd0);
				// Slow slave must have filled the FIFO at some point
				assert (stall_total > 0)
				else begin
					$display("FAIL t=%0t byte_ready never fell while the payload streamed",
					         $time);
					errors++;
				end
				if (!timed_out)
					check_memory(prg_len + chr_len);
				if (chr_len == 0)
					check_value("chr base written", 32'(mem_i.mem_bytes.exists(
					            int'(ines_pkg::CHR_BASE))), 32'd0);
			end
			byte_valid = 1'b0;
		end
		if (errors != errors_before)
			tests_failed++;
		$display("Test %0d %s: %s", r, row_names[r], (errors == errors_before) ? "ok" : "errors");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		reset_nes        = 1'b1;
		byte_data        = 8'h00;
		byte_valid       = 1'b0;
		invert_mirroring = 1'b0;
		seed             = 32'hd05d_4ed9;
		errors           = 0;
		tests_failed     = 0;
		stall_total      = 0;
		timed_out        = 1'b0;
		fill_table();
		foreach (table_rows[r]) begin
			if (!timed_out)
				run_row(r);
		end
		$display("Finished %0d tests, %0d failed, %0d errors", $size(table_rows),
		         tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/wb_mem_model.sv ====
// Wishbone slave memory model
// Byte-wide sparse memory that acks each write after 0 to 3 random
// wait states and counts writes and repeated addresses

`default_nettype none

module wb_mem_model (
	input  wire                    clk,
	input  wire                    reset_nes,
	input  wire ines_pkg::wb_m2s_t wb,
	output logic                   wb_ack
);

	logic [7:0] mem_bytes [int];	// Sparse over the whole address space
	int         write_total;
	int         dup_count;	// Writes that hit an address again
	logic       cyc_seen;
	logic       busy;
	logic [1:0] wait_left;
	int         seed = 32'hd05d_4ed9;

	always @(posedge clk) begin
		if (reset_nes) begin
			wb_ack <= 1'b0;
			busy = 1'b0;
			wait_left = 2'd0;
			write_total = 0;
			dup_count = 0;
			cyc_seen = 1'b0;
			mem_bytes.delete();
		end else begin
			wb_ack <= 1'b0;
			if (wb.cyc)
				cyc_seen = 1'b1;
			// Cycle still open the edge after an ack is the master dropping it
			if (wb.cyc && wb.stb && !wb_ack) begin
				if (!busy) begin
					busy = 1'b1;
					wait_left = 2'($random(seed));	// New cycle
				end
				if (wait_left != 2'd0) begin
					wait_left = wait_left - 2'd1;
				end else begin
					busy = 1'b0;
					wb_ack <= 1'b1;
					if (wb.we) begin
						if (mem_bytes.exists(int'(wb.adr)))
							dup_count++;
						mem_bytes[int'(wb.adr)] = wb.dat;
						write_total++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/cart_loader_top.sv ====
// Cartridge loader top level
// iNES parser feeding a write FIFO that a Wishbone master drains
// into external cartridge memory

`default_nettype none

module cart_loader_top (
	input  wire                       clk,
	input  wire                       reset_nes,
	input  wire [7:0]                 byte_data,
	input  wire                       byte_valid,
	input  wire                       invert_mirroring,
	input  wire                       wb_ack,
	output logic                      byte_ready,
	output ines_pkg::wb_m2s_t         wb,
	output ines_pkg::cart_flags_t     flags,
	output logic                      done,
	output logic                      error
);

	ines_pkg::wr_req_t req;
	ines_pkg::wr_req_t head;
	logic              req_valid;
	logic              nearly_full;
	logic              not_empty;
	logic              pop;

	////////////////////////////////////////
	// Producer
	////////////////////////////////////////

	ines_header_parser parser_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_data        (byte_data),
		.byte_valid       (byte_valid),
		.invert_mirroring (invert_mirroring),
		.nearly_full      (nearly_full),
		.byte_ready       (byte_ready),
		.req              (req),
		.req_valid        (req_valid),
		.flags            (flags),
		.error            (error)
	);

	write_fifo fifo_i (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.req         (req),
		.req_valid   (req_valid),
		.pop         (pop),
		.head        (head),
		.not_empty   (not_empty),
		.nearly_full (nearly_full)
	);

	////////////////////////////////////////
	// Consumer
	////////////////////////////////////////

	wb_mem_writer writer_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.head      (head),
		.not_empty (not_empty),
		.wb_ack    (wb_ack),
		.pop       (pop),
		.wb        (wb),
		.done      (done)
	);

endmodule

`default_nettype wire

// ==== design/wb_mem_writer.sv ====
// Wishbone memory writer
// Classic single-cycle master that drains the request FIFO one byte at
// a time and flags completion after the final write is acked

`default_nettype none

module wb_mem_writer (
	input  wire                    clk,
	input  wire                    reset_nes,
	input  wire ines_pkg::wr_req_t head,
	input  wire                    not_empty,
	input  wire                    wb_ack,
	output logic                   pop,
	output ines_pkg::wb_m2s_t      wb,
	output logic                   done
);

	typedef enum logic {
		S_IDLE,
		S_BUS
	} state_t;

	state_t state;

	logic [ines_pkg::MEM_ADDR_W-1:0] adr_r;
	logic [7:0]                      dat_r;
	logic                            last_r;	// Entry ends the image
	logic                            bus_active;

	////////////////////////////////////////
	// Request fetch
	////////////////////////////////////////

	assign pop = (state == S_IDLE) && not_empty;

	always_ff @(posedge clk) begin
		if (pop) begin
			adr_r  <= head.addr;
			dat_r  <= head.data;
			last_r <= head.last;
		end
	end

	////////////////////////////////////////
	// Bus cycle control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state <= S_IDLE;
			done  <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (not_empty)
						state <= S_BUS;
				end
				S_BUS: begin
					// Slave may stretch the cycle with wait states
					if (wb_ack) begin
						state <= S_IDLE;
						if (last_r)
							done <= 1'b1;	// Sticky until reset
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign bus_active = (state == S_BUS);

	always_comb begin
		wb.cyc = bus_active;
		wb.stb = bus_active;
		wb.we  = bus_active;	// Write-only master
		wb.adr = adr_r;
		wb.dat = dat_r;
	end

endmodule

`default_nettype wire

// ==== design/write_fifo.sv ====
// Write request FIFO
// Circular buffer between the parser and the memory writer, with a
// nearly-full flag that holds off the byte stream

`default_nettype none

module write_fifo #(
	parameter int DEPTH = 8	// Power of two
) (
	input  wire                   clk,
	input  wire                   reset_nes,
	input  wire ines_pkg::wr_req_t req,
	input  wire                   req_valid,
	input  wire                   pop,
	output ines_pkg::wr_req_t     head,
	output logic                  not_empty,
	output logic                  nearly_full
);

	ines_pkg::wr_req_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   count;	// Occupancy

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (req_valid)
			mem[wr_ptr] <= req;
	end

	assign head = mem[rd_ptr];	// Valid whenever not_empty

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (req_valid)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at DEPTH
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({req_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;	// Push and pop together leave count
			endcase
		end
	end

	assign not_empty = (count != '0);

	// One slot spare for the request already in flight from the parser
	assign nearly_full = (count >= DEPTH - 1);

endmodule

`default_nettype wire

// ==== design/ines_header_parser.sv ====
// iNES stream parser
// Captures the 16-byte header, checks magic and trainer, decodes the
// cartridge flags and turns PRG and CHR bytes into addressed writes

`default_nettype none

module ines_header_parser (
	input  wire                       clk,
	input  wire                       reset_nes,
	input  wire [7:0]                 byte_data,
	input  wire                       byte_valid,
	input  wire                       invert_mirroring,
	input  wire                       nearly_full,
	output logic                      byte_ready,
	output ines_pkg::wr_req_t         req,
	output logic                      req_valid,
	output ines_pkg::cart_flags_t     flags,
	output logic                      error
);

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_FINISHED,
		S_ERROR
	} state_t;

	state_t state;

	logic [7:0] hdr [0:ines_pkg::HEADER_LEN-1];	// Raw header bytes
	logic [3:0] hdr_cnt;

	logic [ines_pkg::MEM_ADDR_W-1:0] bytes_left;	// Payload left in section
	logic [ines_pkg::MEM_ADDR_W-1:0] wr_addr;
	logic [ines_pkg::MEM_ADDR_W-1:0] prg_len;
	logic [ines_pkg::MEM_ADDR_W-1:0] chr_len;

	logic [7:0] prg_pages;
	logic [7:0] chr_pages;
	logic       in_payload;
	logic       accept;
	logic       hdr_last;
	logic       magic_ok;
	logic       last_byte;
	logic       is_nes20;
	logic       is_dirty;

	// Smallest k with pages <= 2^k, saturating
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'(ines_pkg::SIZE_CODE_MAX);
		for (int i = ines_pkg::SIZE_CODE_MAX - 1; i >= 0; i--) begin
			if (int'(pages) <= (1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	////////////////////////////////////////
	// Stream handshake
	////////////////////////////////////////

	assign prg_pages  = hdr[4];
	assign chr_pages  = hdr[5];
	assign prg_len    = {{(ines_pkg::MEM_ADDR_W-8){1'b0}}, prg_pages} << ines_pkg::PRG_PAGE_SHIFT;
	assign chr_len    = {{(ines_pkg::MEM_ADDR_W-8){1'b0}}, chr_pages} << ines_pkg::CHR_PAGE_SHIFT;

	assign in_payload = (state == S_PRG) || (state == S_CHR);
	assign byte_ready = !nearly_full && ((state == S_HEADER) || in_payload);
	assign accept     = byte_valid && byte_ready;
	assign hdr_last   = (hdr_cnt == 4'(ines_pkg::HEADER_LEN - 1));

	assign magic_ok = (hdr[0] == ines_pkg::MAGIC_0) && (hdr[1] == ines_pkg::MAGIC_1) &&
	                  (hdr[2] == ines_pkg::MAGIC_2) && (hdr[3] == ines_pkg::MAGIC_3);

	// CHR RAM images end on the last PRG byte
	assign last_byte = (bytes_left == 1) && ((state == S_CHR) || (chr_pages == 8'd0));

	////////////////////////////////////////
	// Load sequencing
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= S_HEADER;
			hdr_cnt    <= '0;
			bytes_left <= '0;
			wr_addr    <= ines_pkg::PRG_BASE;
			req_valid  <= 1'b0;
			error      <= 1'b0;
		end else begin
			req_valid <= accept && in_payload;
			case (state)
				S_HEADER: begin
					if (accept) begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_last) begin
							// Trainers are not supported
							if (!magic_ok || hdr[6][2]) begin
								state <= S_ERROR;
								error <= 1'b1;
							end else if (prg_pages != 8'd0) begin
								state      <= S_PRG;
								wr_addr    <= ines_pkg::PRG_BASE;
								bytes_left <= prg_len;
							end else if (chr_pages != 8'd0) begin
								state      <= S_CHR;
								wr_addr    <= ines_pkg::CHR_BASE;
								bytes_left <= chr_len;
							end else begin
								state <= S_FINISHED;	// Nothing to load
							end
						end
					end
				end
				S_PRG, S_CHR: begin
					if (accept) begin
						bytes_left <= bytes_left - 1'b1;
						wr_addr    <= wr_addr + 1'b1;
						if (bytes_left == 1) begin
							if ((state == S_PRG) && (chr_pages != 8'd0)) begin
								state      <= S_CHR;
								wr_addr    <= ines_pkg::CHR_BASE;
								bytes_left <= chr_len;
							end else begin
								state <= S_FINISHED;
							end
						end
					end
				end
				default: ;	// Finished and error hold until reset
			endcase
		end
	end

	// Header capture and request payload
	always_ff @(posedge clk) begin
		if (accept && (state == S_HEADER))
			hdr[hdr_cnt] <= byte_data;
		if (accept && in_payload) begin
			req.addr <= wr_addr;
			req.data <= byte_data;
			req.last <= last_byte;
		end
	end

	////////////////////////////////////////
	// Flag decode
	////////////////////////////////////////

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumpers left junk in the tail of iNES 1.0 headers
	assign is_dirty = !is_nes20 &&
	                  ((hdr[9][7:1] != 7'd0) || (hdr[10] != 8'd0) || (hdr[11] != 8'd0) ||
	                   (hdr[12] != 8'd0) || (hdr[13] != 8'd0) || (hdr[14] != 8'd0) ||
	                   (hdr[15] != 8'd0));

	always_comb begin
		flags                 = '0;
		flags.mapper          = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		flags.prg_size        = size_code(prg_pages);
		flags.chr_size        = size_code(chr_pages);
		flags.vertical_mirror = hdr[6][0] ^ invert_mirroring;
		flags.has_chr_ram     = (chr_pages == 8'd0);
		flags.four_screen     = hdr[6][3];
		flags.has_saves       = hdr[6][1];
		flags.ines2_mapper    = is_nes20 ? hdr[8] : 8'h00;
		flags.prg_ram_shift   = is_nes20 ? hdr[10][3:0] : 4'h0;	// NES 2.0 only
	end

endmodule

`default_nettype wire

// ==== design/ines_pkg.sv ====
// iNES cartridge loader definitions
// Header constants, external memory map, size codes and the packed
// structs that travel between the loader blocks

`default_nettype none

package ines_pkg;

	////////////////////////////////////////
	// Header and memory map
	////////////////////////////////////////

	localparam int MEM_ADDR_W = 22;	// Byte address into cartridge memory
	localparam int HEADER_LEN = 16;

	localparam int PRG_PAGE_SHIFT = 14;	// 16 KiB PRG pages
	localparam int CHR_PAGE_SHIFT = 13;	// 8 KiB CHR pages

	localparam logic [MEM_ADDR_W-1:0] PRG_BASE = 22'h000000;
	localparam logic [MEM_ADDR_W-1:0] CHR_BASE = 22'h200000;	// Upper half of memory

	// "NES" then MS-DOS end of file
	localparam logic [7:0] MAGIC_0 = 8'h4E;
	localparam logic [7:0] MAGIC_1 = 8'h45;
	localparam logic [7:0] MAGIC_2 = 8'h53;
	localparam logic [7:0] MAGIC_3 = 8'h1A;

	// Size code k covers up to 2^k pages
	localparam int SIZE_CODE_MAX = 7;

	////////////////////////////////////////
	// Write request
	////////////////////////////////////////

	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  last;	// Final byte of the image
	} wr_req_t;

	////////////////////////////////////////
	// Wishbone master outputs
	////////////////////////////////////////

	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [MEM_ADDR_W-1:0] adr;
		logic [7:0]            dat;
	} wb_m2s_t;

	////////////////////////////////////////
	// Decoded cartridge flags
	////////////////////////////////////////

	// Same bit layout the console core expects for its mapper flags
	typedef struct packed {
		logic [1:0] spare;	// Always zero
		logic [3:0] prg_ram_shift;	// NES 2.0 PRG RAM is 64 << shift
		logic       has_saves;	// Battery backed RAM
		logic [7:0] ines2_mapper;	// Raw byte 8 for NES 2.0
		logic       four_screen;
		logic       has_chr_ram;	// No CHR ROM pages
		logic       vertical_mirror;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} cart_flags_t;

endpackage

`default_nettype wire
